/* verilog.f */
src/host_pkg.sv
src/cart_pkg.sv
src/download_decode.sv
src/header_detect.sv
src/cheat_loader.sv
src/ram_clear.sv
src/audio_mix.sv
src/cart_loader_top.sv
testbench/tb_cart_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	-f verilog.f \
	--top-module tb_cart_loader \
	-o tb_cart_loader
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/tb_cart_loader
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation failed with status $sim_status"
	exit $sim_status
fi

echo "Simulation finished cleanly"
exit 0

/* testbench/tb_cart_loader.sv */
// Directed-test testbench for cart_loader_top, run through verilog.f and run_sim.sh
`timescale 1ns/1ps

module tb_cart_loader
	import host_pkg::*;
	import cart_pkg::*;
();

	// One full clear is a write cycle and a wait cycle per address
	localparam int CLEAR_CYCLES   = 2 * (1 << FILL_ADDR_W);
	localparam int OTHER_CYCLES   = 300;
	localparam int TIMEOUT_CYCLES = CLEAR_CYCLES + OTHER_CYCLES + 1000;

	logic         clk_sys;
	logic         RESET;
	logic         ioctl_download;
	logic         ioctl_wr;
	io_index_t    ioctl_index;
	io_addr_t     ioctl_addr;
	io_word_t     ioctl_dout;
	header_mode_t header_mode;
	logic [1:0]   video_region;
	fill_mode_t   wram_mode, aram_mode;
	sample_t      main_l, main_r, track_l, track_r;

	logic                   spc_dl, load_end, spc_mode, rom_wr, core_hold;
	rom_addr_t              rom_addr;
	io_word_t               rom_data;
	rom_type_t              rom_type;
	size_code_t             ram_size;
	mask_t                  rom_mask, ram_mask;
	logic                   pal;
	cheat_code_t            cheat_code;
	logic                   cheat_strobe, cheat_clear, clearing, fill_we;
	logic [FILL_ADDR_W-1:0] fill_addr;
	logic [7:0]             wram_fill, aram_fill, bsram_fill;
	sample_t                mix_l, mix_r;

	logic [31:0] lfsr_state;
	int          cycle_count;

	cart_loader_top dut_i (.*);

	always #10 clk_sys = ~clk_sys;

	// Watchdog
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$fatal(1, "Watchdog expired");
		end
	end

	// ==============================
	// Random source
	// ==============================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return r;
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic report_value(input string name, input string got, input string exp);
		$display("FAIL at %0t ns: %s got %s expected %s", $time, name, got, exp);
		$display("*** FAILED ***");
		$fatal(1, "Mismatch on %s", name);
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("*** FAILED ***");
		$fatal(1, "%s", what);
	endtask

	task automatic check_rom_type(input string name, input rom_type_t got, input rom_type_t exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_mask(input string name, input mask_t got, input mask_t exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_size(input string name, input size_code_t got, input size_code_t exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_code(input string name, input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp)
			report_value(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_value(name, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_word(input string name, input io_word_t got, input io_word_t exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_fill(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_fill_addr(input string name, input logic [FILL_ADDR_W-1:0] got,
		input logic [FILL_ADDR_W-1:0] exp);
		if (got !== exp)
			report_value(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	// ==============================
	// Reference rules
	// ==============================
	function automatic mask_t size_mask(input size_code_t code);
		longint bytes;
		bytes = longint'(1024) << code;
		return mask_t'(bytes - 1);
	endfunction

	function automatic logic [7:0] expected_fill(input fill_mode_t mode,
		input logic [FILL_ADDR_W-1:0] addr);
		if (mode == 2'd0)
			return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
		if (mode == 2'd1)
			return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		if (mode == 2'd2)
			return 8'h55;
		return 8'hFF;
	endfunction

	function automatic sample_t expected_mix(input sample_t a, input sample_t b);
		int s;
		s = int'(a) + int'(b);
		if (s > 32767)
			s = 32767;
		else if (s < -32768)
			s = -32768;
		return sample_t'(s);
	endfunction

	// ==============================
	// Host bus drivers
	// ==============================
	task automatic start_download(input io_index_t idx);
		ioctl_index    = idx;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic drive_write(input io_addr_t addr, input io_word_t data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
	endtask

	// Write strobe for one cycle, returns on the following falling edge
	task automatic host_write(input io_addr_t addr, input io_word_t data);
		drive_write(addr, data);
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic test_reset_state();
		check_bit("rom_wr", rom_wr, 1'b0);
		check_bit("cheat_strobe", cheat_strobe, 1'b0);
		check_bit("clearing", clearing, 1'b0);
		check_bit("fill_we", fill_we, 1'b0);
		check_bit("load_end", load_end, 1'b0);
	endtask

	task automatic test_memory_clear();
		logic [FILL_ADDR_W-1:0] addr_exp;
		int n;
		n = 0;
		start_download(8'h01);
		while (!clearing) begin
			if (n == 4)
				report_error("clearing did not rise after the cartridge load started");
			@(negedge clk_sys);
			n++;
		end
		// First write cycle on address 0 is under way
		ioctl_download = 1'b0;
		for (int k = 0; k < (1 << FILL_ADDR_W); k++) begin
			addr_exp  = k[FILL_ADDR_W-1:0];
			wram_mode = (k >= 32 && k < 64) ? 2'd2 : 2'd0;
			aram_mode = (k >= 32 && k < 64) ? 2'd3 : 2'd1;
			#1;
			// Hold now comes from the clear alone
			if (k == 0) begin
				check_bit("core_hold", core_hold, 1'b1);
				check_fill("bsram_fill", bsram_fill, 8'hFF);
			end
			check_bit("fill_we", fill_we, 1'b1);
			check_fill_addr("fill_addr", fill_addr, addr_exp);
			check_fill("wram_fill", wram_fill, expected_fill(wram_mode, addr_exp));
			check_fill("aram_fill", aram_fill, expected_fill(aram_mode, addr_exp));
			@(negedge clk_sys);
			check_bit("fill_we", fill_we, 1'b0);
			check_bit("clearing", clearing, 1'b1);
			@(negedge clk_sys);
		end
		check_bit("clearing", clearing, 1'b0);
		check_bit("fill_we", fill_we, 1'b0);
	endtask

	task automatic test_auto_header();
		rom_type_t  type_byte;
		size_code_t rom_code;
		size_code_t ram_code;
		type_byte    = rom_type_t'(rand_bits(8));
		rom_code     = size_code_t'(4'd7 + rand_bits(3));
		ram_code     = size_code_t'(4'd1 + rand_bits(2));
		header_mode  = 3'd0;
		video_region = 2'd0;
		start_download(8'h01);
		host_write(25'd0, {type_byte, ram_code, rom_code});
		host_write(25'd2, {7'(rand_bits(7)), 1'b1, 8'(rand_bits(8))});
		end_download();
		// Falling download level gives one load_end pulse
		check_bit("load_end", load_end, 1'b1);
		repeat (2) @(negedge clk_sys);
		check_bit("load_end", load_end, 1'b0);
		check_rom_type("rom_type", rom_type, type_byte);
		check_size("ram_size", ram_size, ram_code);
		check_mask("rom_mask", rom_mask, size_mask(rom_code));
		check_mask("ram_mask", ram_mask, size_mask(ram_code));
		check_bit("pal", pal, 1'b1);
		// User region overrides the header
		video_region = 2'd1;
		@(negedge clk_sys);
		check_bit("pal", pal, 1'b0);
		video_region = 2'd2;
		@(negedge clk_sys);
		check_bit("pal", pal, 1'b1);
		video_region = 2'd0;
	endtask

	task automatic test_mapped_header();
		header_mode = 3'd3;
		start_download(8'h01);
		host_write(25'd0, io_word_t'(rand_bits(16)));
		host_write(25'h00FFD6 + 25'd512, {4'(rand_bits(4)), 4'hA, 8'(rand_bits(8))});
		host_write(25'h00FFD8 + 25'd512, {12'(rand_bits(12)), 4'h3});
		@(negedge clk_sys);
		check_size("ram_size", ram_size, 4'h3);
		check_mask("ram_mask", ram_mask, size_mask(4'h3));
		host_write(25'h00FFD8 + 25'd512, {12'(rand_bits(12)), 4'h0});
		end_download();
		repeat (2) @(negedge clk_sys);
		check_rom_type("rom_type", rom_type, 8'd1);
		check_mask("rom_mask", rom_mask, size_mask(4'hA));
		check_size("ram_size", ram_size, 4'h0);
		check_mask("ram_mask", ram_mask, '0);
		header_mode = 3'd0;
	endtask

	task automatic test_spc_download();
		start_download(8'h04);
		check_bit("spc_dl", spc_dl, 1'b1);
		host_write(io_addr_t'(rand_bits(16)), io_word_t'(rand_bits(16)));
		check_bit("spc_mode", spc_mode, 1'b1);
		check_bit("rom_wr", rom_wr, 1'b0);
		end_download();
		check_bit("spc_dl", spc_dl, 1'b0);
	endtask

	task automatic test_rom_path();
		io_addr_t addr;
		io_word_t data;
		start_download(8'h01);
		for (int i = 0; i < 8; i++) begin
			addr = 25'd512 + io_addr_t'(rand_bits(23));
			data = io_word_t'(rand_bits(16));
			host_write(addr, data);
			check_bit("rom_wr", rom_wr, 1'b1);
			check_bit("spc_mode", spc_mode, 1'b0);
			check_rom_addr("rom_addr", rom_addr, rom_addr_t'(addr - 25'd512));
			check_word("rom_data", rom_data, data);
			@(negedge clk_sys);
			check_bit("rom_wr", rom_wr, 1'b0);
		end
		end_download();
		// State binary goes to the top bank
		start_download(8'h40);
		addr = io_addr_t'(rand_bits(25));
		data = io_word_t'(rand_bits(16));
		host_write(addr, data);
		check_bit("rom_wr", rom_wr, 1'b1);
		check_rom_addr("rom_addr", rom_addr, {8'hFF, addr[15:0]});
		check_word("rom_data", rom_data, data);
		end_download();
	endtask

	task automatic test_cheat();
		io_word_t    w[8];
		cheat_code_t exp;
		start_download(8'hFF);
		check_bit("cheat_clear", cheat_clear, 1'b0);
		for (int i = 0; i < 8; i++) begin
			w[i] = io_word_t'(rand_bits(16));
			drive_write(io_addr_t'(2 * i), w[i]);
			#1;
			check_bit("cheat_clear", cheat_clear, i == 0);
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_bit("cheat_strobe", cheat_strobe, i == 7);
		end
		exp = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		check_code("cheat_code", cheat_code, exp);
		@(negedge clk_sys);
		check_bit("cheat_strobe", cheat_strobe, 1'b0);
		end_download();
	endtask

	task automatic mix_pair(input sample_t a, input sample_t b, input sample_t c,
		input sample_t d);
		main_l  = a;
		track_l = b;
		main_r  = c;
		track_r = d;
		@(negedge clk_sys);
		check_sample("mix_l", mix_l, expected_mix(a, b));
		check_sample("mix_r", mix_r, expected_mix(c, d));
	endtask

	task automatic test_audio_mix();
		mix_pair(16'sd32767, 16'sd1, -16'sd32768, -16'sd1);
		mix_pair(16'sd32767, 16'sd32767, -16'sd32768, -16'sd32768);
		mix_pair(16'sd32767, -16'sd32768, 16'sd16384, -16'sd16385);
		mix_pair(16'sd16384, 16'sd16384, -16'sd16384, -16'sd16385);
		for (int i = 0; i < 12; i++)
			mix_pair(sample_t'(rand_bits(16)), sample_t'(rand_bits(16)),
				sample_t'(rand_bits(16)), sample_t'(rand_bits(16)));
	endtask

	// ==============================
	// Sequence
	// ==============================
	initial begin
		clk_sys        = 1'b0;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		header_mode    = 3'd0;
		video_region   = 2'd0;
		wram_mode      = 2'd0;
		aram_mode      = 2'd0;
		main_l         = '0;
		main_r         = '0;
		track_l        = '0;
		track_r        = '0;
		lfsr_state     = 32'hd87e;
		cycle_count    = 0;
		repeat (4) @(negedge clk_sys);
		RESET = 1'b0;
		test_reset_state();
		test_memory_clear();
		test_auto_header();
		test_mapped_header();
		test_spc_download();
		test_rom_path();
		test_cheat();
		test_audio_mix();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* src/cart_loader_top.sv */
// Top of the cartridge loader and audio path, joins decode, header, cheat, clear and mix blocks
`timescale 1ns/1ps

module cart_loader_top
	import host_pkg::*;
	import cart_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  io_index_t              ioctl_index,
	input  io_addr_t               ioctl_addr,
	input  io_word_t               ioctl_dout,
	input  header_mode_t           header_mode,
	input  logic [1:0]             video_region,
	input  fill_mode_t             wram_mode,
	input  fill_mode_t             aram_mode,
	input  sample_t                main_l,
	input  sample_t                main_r,
	input  sample_t                track_l,
	input  sample_t                track_r,
	output logic                   spc_dl,
	output logic                   load_end,
	output logic                   spc_mode,
	output logic                   rom_wr,
	output logic                   core_hold,
	output rom_addr_t              rom_addr,
	output io_word_t               rom_data,
	output rom_type_t              rom_type,
	output size_code_t             ram_size,
	output mask_t                  rom_mask,
	output mask_t                  ram_mask,
	output logic                   pal,
	output cheat_code_t            cheat_code,
	output logic                   cheat_strobe,
	output logic                   cheat_clear,
	output logic                   clearing,
	output logic                   fill_we,
	output logic [FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]             wram_fill,
	output logic [7:0]             aram_fill,
	output logic [7:0]             bsram_fill,
	output sample_t                mix_l,
	output sample_t                mix_r
);

	logic cart_dl;
	logic code_dl;
	logic load_start;

	// ==============================
	// Host side
	// ==============================
	download_decode decode_i (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.clearing       (clearing),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.cart_dl        (cart_dl),
		.spc_dl         (spc_dl),
		.code_dl        (code_dl),
		.load_start     (load_start),
		.load_end       (load_end),
		.spc_mode       (spc_mode),
		.rom_wr         (rom_wr),
		.core_hold      (core_hold),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data)
	);

	header_detect header_i (
		.clk_sys      (clk_sys),
		.cart_dl      (cart_dl),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.header_mode  (header_mode),
		.video_region (video_region),
		.rom_type     (rom_type),
		.ram_size     (ram_size),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.pal          (pal)
	);

	cheat_loader cheat_i (
		.clk_sys      (clk_sys),
		.code_dl      (code_dl),
		.cart_dl      (cart_dl),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe),
		.cheat_clear  (cheat_clear)
	);

	// ==============================
	// Memory clear and audio
	// ==============================
	ram_clear clear_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.load_start (load_start),
		.wram_mode  (wram_mode),
		.aram_mode  (aram_mode),
		.clearing   (clearing),
		.fill_we    (fill_we),
		.fill_addr  (fill_addr),
		.wram_fill  (wram_fill),
		.aram_fill  (aram_fill),
		.bsram_fill (bsram_fill)
	);

	audio_mix mix_i (
		.clk_sys (clk_sys),
		.main_l  (main_l),
		.main_r  (main_r),
		.track_l (track_l),
		.track_r (track_r),
		.mix_l   (mix_l),
		.mix_r   (mix_r)
	);

endmodule

/* src/audio_mix.sv */
// Adds console and streamed-track stereo audio with clamping, one register stage
`timescale 1ns/1ps

module audio_mix
	import host_pkg::*;
(
	input  logic    clk_sys,
	input  sample_t main_l,
	input  sample_t main_r,
	input  sample_t track_l,
	input  sample_t track_r,
	output sample_t mix_l,
	output sample_t mix_r
);

	// 17-bit sum, top two bits differ on overflow
	function automatic sample_t sat_add(sample_t a, sample_t b);
		logic signed [16:0] sum;
		sum = {a[15], a} + {b[15], b};
		if (sum[16] ^ sum[15])
			sat_add = {sum[16], {15{sum[15]}}};
		else
			sat_add = sum[15:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		mix_l <= sat_add(main_l, track_l);
		mix_r <= sat_add(main_r, track_r);
	end

endmodule

/* src/ram_clear.sv */
// Walks the clear address after a cartridge load starts and supplies the RAM fill bytes
`timescale 1ns/1ps

module ram_clear
	import cart_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   load_start,
	input  fill_mode_t             wram_mode,
	input  fill_mode_t             aram_mode,
	output logic                   clearing,
	output logic                   fill_we,
	output logic [FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]             wram_fill,
	output logic [7:0]             aram_fill,
	output logic [7:0]             bsram_fill
);

	logic fill_wait;

	// ==============================
	// Address sequencer
	// ==============================
	// Write cycle then wait cycle on every address
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_wait <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (clearing) begin
				fill_wait <= ~fill_wait;
				if (fill_wait) begin
					fill_addr <= fill_addr + 1'b1;
					if (&fill_addr)
						clearing <= 1'b0;
				end
			end else begin
				fill_wait <= 1'b0;
				fill_addr <= '0;
			end
			if (load_start)
				clearing <= 1'b1;
		end
	end

	assign fill_we = clearing & ~fill_wait;

	// ==============================
	// Fill patterns
	// ==============================
	function automatic logic [7:0] fill_byte(fill_mode_t mode,
		logic [FILL_ADDR_W-1:0] addr);
		case (mode)
			2'd0:    fill_byte = (addr[8] ^ addr[2]) ? FILL_A : FILL_B;
			2'd1:    fill_byte = (addr[9] ^ addr[0]) ? FILL_FF : 8'h00;
			2'd2:    fill_byte = FILL_55;
			default: fill_byte = FILL_FF;
		endcase
	endfunction

	assign wram_fill  = fill_byte(wram_mode, fill_addr);
	assign aram_fill  = fill_byte(aram_mode, fill_addr);
	assign bsram_fill = BSRAM_FILL;

endmodule

/* src/cheat_loader.sv */
// Builds one cheat code from eight 16-bit writes and strobes it into the core
`timescale 1ns/1ps

module cheat_loader
	import host_pkg::*;
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        code_dl,
	input  logic        cart_dl,
	input  logic        ioctl_wr,
	input  io_addr_t    ioctl_addr,
	input  io_word_t    ioctl_dout,
	output cheat_code_t cheat_code,
	output logic        cheat_strobe,
	output logic        cheat_clear
);

	logic code_wr;

	assign code_wr = code_dl & ioctl_wr;

	// New image or a fresh cheat file drops all codes
	assign cheat_clear = cart_dl | (code_wr & (ioctl_addr == '0));

	// Each 16-byte record is low word first for every field
	always_ff @(posedge clk_sys) begin
		cheat_strobe <= 1'b0;
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl_dout;
				4'd2:  cheat_code.flags[31:16]   <= ioctl_dout;
				4'd4:  cheat_code.address[15:0]  <= ioctl_dout;
				4'd6:  cheat_code.address[31:16] <= ioctl_dout;
				4'd8:  cheat_code.compare[15:0]  <= ioctl_dout;
				4'd10: cheat_code.compare[31:16] <= ioctl_dout;
				4'd12: cheat_code.replace[15:0]  <= ioctl_dout;
				4'd14: begin
					cheat_code.replace[31:16] <= ioctl_dout;
					// Record complete
					cheat_strobe <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

/* src/header_detect.sv */
// Picks ROM type, sizes and region out of the cartridge stream and derives the address masks
`timescale 1ns/1ps

module header_detect
	import host_pkg::*;
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         cart_dl,
	input  logic         ioctl_wr,
	input  io_addr_t     ioctl_addr,
	input  io_word_t     ioctl_dout,
	input  header_mode_t header_mode,
	input  logic [1:0]   video_region,
	output rom_type_t    rom_type,
	output size_code_t   ram_size,
	output mask_t        rom_mask,
	output mask_t        ram_mask,
	output logic         pal
);

	size_code_t  rom_size;
	logic        rom_region;
	logic        hdr_wr;
	logic        mapped;
	logic [24:0] size_addr;

	assign hdr_wr = cart_dl & ioctl_wr;

	// Where the internal header sits for the chosen map
	always_comb begin
		mapped    = 1'b1;
		size_addr = HDR_LO_SIZE;
		case (header_mode)
			HDR_LO: size_addr = HDR_LO_SIZE;
			HDR_HI: size_addr = HDR_HI_SIZE;
			HDR_EX: size_addr = HDR_EX_SIZE;
			default: mapped = 1'b0;
		endcase
	end

	// ==============================
	// Field capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Auto mode: loader prepends its own size byte
				if (header_mode == HDR_AUTO && ioctl_dout[7:0] != '0)
					{ram_size, rom_size} <= ioctl_dout[7:0];

				case (header_mode)
					HDR_NONE,
					HDR_LO:  rom_type <= 8'd0;
					HDR_HI:  rom_type <= 8'd1;
					HDR_EX:  rom_type <= 8'd2;
					default: rom_type <= ioctl_dout[15:8];
				endcase
			end

			if (ioctl_addr == 25'd2)
				rom_region <= ioctl_dout[8];

			if (mapped) begin
				if (ioctl_addr == size_addr)
					rom_size <= ioctl_dout[11:8];
				if (ioctl_addr == size_addr + HDR_RAM_OFS)
					ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// ==============================
	// Masks and region
	// ==============================
	always_ff @(posedge clk_sys) begin
		rom_mask <= (mask_t'(1024) << rom_size) - mask_t'(1);
		if (ram_size != '0)
			ram_mask <= (mask_t'(1024) << ram_size) - mask_t'(1);
		else
			ram_mask <= '0;
	end

	// Region held steady while a new image streams in
	always_ff @(posedge clk_sys) begin
		if (!cart_dl)
			pal <= (video_region == 2'd0) ? rom_region : video_region[1];
	end

endmodule

/* src/download_decode.sv */
// Classifies the host download, marks load start and end, and drives the ROM write path and hold
`timescale 1ns/1ps

module download_decode
	import host_pkg::*;
	import cart_pkg::*;
(
	input  logic      clk_sys,
	input  logic      RESET,
	input  logic      clearing,
	input  logic      ioctl_download,
	input  logic      ioctl_wr,
	input  io_index_t ioctl_index,
	input  io_addr_t  ioctl_addr,
	input  io_word_t  ioctl_dout,
	output logic      cart_dl,
	output logic      spc_dl,
	output logic      code_dl,
	output logic      load_start,
	output logic      load_end,
	output logic      spc_mode,
	output logic      rom_wr,
	output logic      core_hold,
	output rom_addr_t rom_addr,
	output io_word_t  rom_data
);

	logic     ssbin_dl;
	logic     msu_data_dl;
	logic     cart_dl_q;
	io_addr_t cart_addr;

	// ==============================
	// File kind
	// ==============================
	// Index 0 is also a cartridge
	assign cart_dl = ioctl_download &
		((ioctl_index[5:0] == IDX_CART) || (ioctl_index == '0));
	assign spc_dl      = ioctl_download & (ioctl_index[5:0] == IDX_SPC);
	assign msu_data_dl = ioctl_download & (ioctl_index[5:0] == IDX_MSU_DATA);
	assign code_dl     = ioctl_download & (&ioctl_index);
	assign ssbin_dl    = ioctl_download & (ioctl_index[5:0] == '0) &
		(ioctl_index[7:6] == IDX_SSBIN_HI);

	// Console core stays in reset while anything it runs from is changing
	assign core_hold = RESET | cart_dl | spc_dl | msu_data_dl | clearing;

	// Edge pulses on the cartridge download level
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q  <= 1'b0;
			load_start <= 1'b0;
			load_end   <= 1'b0;
			spc_mode   <= 1'b0;
		end else begin
			cart_dl_q  <= cart_dl;
			load_start <= cart_dl & ~cart_dl_q;
			load_end   <= ~cart_dl & cart_dl_q;
			if (ioctl_wr)
				spc_mode <= spc_dl;
		end
	end

	// ==============================
	// ROM write path
	// ==============================
	assign cart_addr = ioctl_addr - CART_SKIP;

	always_ff @(posedge clk_sys) begin
		if (RESET)
			rom_wr <= 1'b0;
		else
			rom_wr <= ioctl_wr & (cart_dl | ssbin_dl);
	end

	// State binary lands in the top 64K bank
	always_ff @(posedge clk_sys) begin
		rom_addr <= ssbin_dl ? {8'hFF, ioctl_addr[15:0]} : cart_addr[23:0];
		rom_data <= ioctl_dout;
	end

endmodule

/* src/cart_pkg.sv */
// Cartridge header layout, ROM type and mask types, cheat code layout and RAM fill patterns
package cart_pkg;

	// ==============================
	// ROM addressing and header
	// ==============================
	typedef logic [23:0] rom_addr_t;
	typedef logic [23:0] mask_t;
	typedef logic [7:0]  rom_type_t;

	// Size in bytes is 1024 << code
	typedef logic [3:0] size_code_t;

	// Header mode as picked by the user
	typedef logic [2:0] header_mode_t;

	localparam header_mode_t HDR_AUTO = 3'd0;
	localparam header_mode_t HDR_NONE = 3'd1;
	localparam header_mode_t HDR_LO   = 3'd2;
	localparam header_mode_t HDR_HI   = 3'd3;
	localparam header_mode_t HDR_EX   = 3'd4;

	// Internal header size word per map, past the copier header
	localparam logic [24:0] HDR_LO_SIZE = 25'h007FD6 + 25'h200;
	localparam logic [24:0] HDR_HI_SIZE = 25'h00FFD6 + 25'h200;
	localparam logic [24:0] HDR_EX_SIZE = 25'h40FFD6 + 25'h200;

	// RAM size word follows two bytes later
	localparam logic [24:0] HDR_RAM_OFS = 25'd2;

	localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;

	// ==============================
	// Cheat codes
	// ==============================
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ==============================
	// Memory clear
	// ==============================
	localparam int FILL_ADDR_W = 18;

	typedef logic [1:0] fill_mode_t;

	// Mode 0 alternates these two bytes
	localparam logic [7:0] FILL_A = 8'h66;
	localparam logic [7:0] FILL_B = 8'h99;

	localparam logic [7:0] FILL_55 = 8'h55;
	localparam logic [7:0] FILL_FF = 8'hFF;

	localparam logic [7:0] BSRAM_FILL = 8'hFF;

endpackage

/* src/host_pkg.sv */
// Host loader bus types, file index codes and the audio sample type for host-facing RTL
package host_pkg;

	// ==============================
	// Host loader bus
	// ==============================
	typedef logic [24:0] io_addr_t;
	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  io_index_t;

	// File kinds, compared against the low six index bits
	localparam logic [5:0] IDX_CART      = 6'd1;
	localparam logic [5:0] IDX_MSU_AUDIO = 6'd2;
	localparam logic [5:0] IDX_MSU_DATA  = 6'd3;
	localparam logic [5:0] IDX_SPC       = 6'd4;

	// State binary: top two bits are 01, low six bits are zero
	localparam logic [1:0] IDX_SSBIN_HI = 2'd1;

	// Copier header in front of the cartridge image
	localparam io_addr_t CART_SKIP = 25'd512;

	// ==============================
	// Audio
	// ==============================
	typedef logic signed [15:0] sample_t;

endpackage
